/* mat_mul_pkg.sv */
package mat_mul_pkg;

    // largest row or column count of an operand
    localparam int MAX_DIM = 5;

    // element slots per matrix
    localparam int GRID_SIZE = MAX_DIM * MAX_DIM;

    // row or column count, legal range 1 to MAX_DIM
    typedef logic [2:0] dim_t;

    // slot index 0 to GRID_SIZE-1
    typedef logic [4:0] index_t;

    // matrix shape, rows in the upper bits
    typedef struct packed {
        dim_t rows;
        dim_t cols;
    } mat_shape_t;

endpackage

/* mat_pack.sv */
`timescale 1ns/1ps

module mat_pack #(
    parameter int DATA_WIDTH = 9
) (
    input  logic                                                clk,
    input  logic                                                reset_n,
    input  logic                                                load,
    input  mat_mul_pkg::mat_shape_t                             shape,
    input  logic [mat_mul_pkg::GRID_SIZE-1:0][DATA_WIDTH-1:0]   dense_in,
    output logic [mat_mul_pkg::GRID_SIZE-1:0][DATA_WIDTH-1:0]   grid
);

    logic [mat_mul_pkg::GRID_SIZE-1:0][DATA_WIDTH-1:0] grid_next;

    // dense slot r*cols+c lands at grid position r*MAX_DIM+c
    always_comb begin
        int src;
        grid_next = '0;
        for (int r = 0; r < mat_mul_pkg::MAX_DIM; r++) begin
            for (int c = 0; c < mat_mul_pkg::MAX_DIM; c++) begin
                src = r * int'(shape.cols) + c;
                if (r < int'(shape.rows) && c < int'(shape.cols) &&
                    src < mat_mul_pkg::GRID_SIZE) begin
                    grid_next[r * mat_mul_pkg::MAX_DIM + c] = dense_in[src];
                end
            end
        end
    end

    // operand held for the whole job
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            grid <= '0;
        end else if (load) begin
            grid <= grid_next;
        end
    end

endmodule

/* mat_dot_engine.sv */
`timescale 1ns/1ps

module mat_dot_engine #(
    parameter int DATA_WIDTH = 9
) (
    input  logic                                                clk,
    input  logic                                                reset_n,
    input  logic                                                start,
    input  logic [mat_mul_pkg::GRID_SIZE-1:0][DATA_WIDTH-1:0]   grid_a,
    input  logic [mat_mul_pkg::GRID_SIZE-1:0][DATA_WIDTH-1:0]   grid_b,
    output logic [mat_mul_pkg::GRID_SIZE-1:0][DATA_WIDTH-1:0]   result_grid,
    output logic                                                done
);

    logic                    running;
    mat_mul_pkg::index_t     idx;
    mat_mul_pkg::dim_t       row_idx;
    mat_mul_pkg::dim_t       col_idx;

    logic [mat_mul_pkg::MAX_DIM-1:0][DATA_WIDTH-1:0] a_row;
    logic [mat_mul_pkg::MAX_DIM-1:0][DATA_WIDTH-1:0] b_col;
    logic [mat_mul_pkg::MAX_DIM-1:0][DATA_WIDTH-1:0] prod;

    logic [DATA_WIDTH-1:0] sum_01;
    logic [DATA_WIDTH-1:0] sum_23;
    logic [DATA_WIDTH-1:0] sum_0123;
    logic [DATA_WIDTH-1:0] dot;

    assign row_idx = mat_mul_pkg::dim_t'(idx / mat_mul_pkg::MAX_DIM);
    assign col_idx = mat_mul_pkg::dim_t'(idx % mat_mul_pkg::MAX_DIM);

    // row of A and column of B for the current position
    always_comb begin
        for (int t = 0; t < mat_mul_pkg::MAX_DIM; t++) begin
            a_row[t] = grid_a[int'(row_idx) * mat_mul_pkg::MAX_DIM + t];
            b_col[t] = grid_b[t * mat_mul_pkg::MAX_DIM + int'(col_idx)];
        end
    end

    // five multipliers, each wraps to DATA_WIDTH
    always_comb begin
        for (int t = 0; t < mat_mul_pkg::MAX_DIM; t++) begin
            prod[t] = a_row[t] * b_col[t];
        end
    end

    // adder tree
    assign sum_01   = prod[0] + prod[1];
    assign sum_23   = prod[2] + prod[3];
    assign sum_0123 = sum_01 + sum_23;
    assign dot      = sum_0123 + prod[4];

    // last position in flight
    assign done = running && (idx == mat_mul_pkg::index_t'(mat_mul_pkg::GRID_SIZE - 1));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            running <= 1'b0;
            idx     <= '0;
        end else if (start) begin
            running <= 1'b1;
            idx     <= '0;
        end else if (running) begin
            if (done) begin
                running <= 1'b0;
                idx     <= '0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    // one result element per clock
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            result_grid <= '0;
        end else if (running) begin
            result_grid[idx] <= dot;
        end
    end

endmodule

/* mat_unpack.sv */
`timescale 1ns/1ps

module mat_unpack #(
    parameter int DATA_WIDTH = 9
) (
    input  logic                                                clk,
    input  logic                                                reset_n,
    input  logic                                                out_load,
    input  logic                                                clear,
    input  mat_mul_pkg::mat_shape_t                             out_shape,
    input  logic [mat_mul_pkg::GRID_SIZE-1:0][DATA_WIDTH-1:0]   result_grid,
    output mat_mul_pkg::mat_shape_t                             shape_out,
    output logic [mat_mul_pkg::GRID_SIZE-1:0][DATA_WIDTH-1:0]   data_out
);

    logic [mat_mul_pkg::GRID_SIZE-1:0][DATA_WIDTH-1:0] dense_next;

    // grid position i,j goes to dense slot i*cols+j, the rest stays zero
    always_comb begin
        int dst;
        dense_next = '0;
        for (int i = 0; i < mat_mul_pkg::MAX_DIM; i++) begin
            for (int j = 0; j < mat_mul_pkg::MAX_DIM; j++) begin
                dst = i * int'(out_shape.cols) + j;
                if (i < int'(out_shape.rows) && j < int'(out_shape.cols) &&
                    dst < mat_mul_pkg::GRID_SIZE) begin
                    dense_next[dst] = result_grid[i * mat_mul_pkg::MAX_DIM + j];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            shape_out <= '0;
            data_out  <= '0;
        end else if (clear) begin
            shape_out <= '0;
            data_out  <= '0;
        end else if (out_load) begin
            shape_out <= out_shape;
            data_out  <= dense_next;
        end
    end

endmodule

/* mat_mul_ctrl.sv */
`timescale 1ns/1ps

module mat_mul_ctrl (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    en,
    input  mat_mul_pkg::mat_shape_t shape_a,
    input  mat_mul_pkg::mat_shape_t shape_b,
    input  logic                    done,
    output logic                    load,
    output logic                    start,
    output logic                    out_load,
    output logic                    clear,
    output mat_mul_pkg::mat_shape_t out_shape,
    output logic                    busy,
    output logic                    is_valid
);

    typedef enum logic [2:0] {
        st_idle,
        st_check,
        st_compute,
        st_output,
        st_finished,
        st_error
    } state_t;

    state_t                  state;
    mat_mul_pkg::mat_shape_t shape_a_q;
    mat_mul_pkg::mat_shape_t shape_b_q;
    logic                    dims_ok;

    function automatic logic dim_in_range(input mat_mul_pkg::dim_t d);
        return (d != '0) && (int'(d) <= mat_mul_pkg::MAX_DIM);
    endfunction

    // inner dimensions agree and every count is 1 to 5
    assign dims_ok = (shape_a_q.cols == shape_b_q.rows) &&
                     dim_in_range(shape_a_q.rows) && dim_in_range(shape_a_q.cols) &&
                     dim_in_range(shape_b_q.rows) && dim_in_range(shape_b_q.cols);

    assign load      = (state == st_idle) && en;
    assign start     = (state == st_check) && dims_ok;
    assign out_load  = (state == st_output);
    assign clear     = ((state == st_finished) || (state == st_error)) && !en;

    // product is rows of A by cols of B
    assign out_shape = '{rows: shape_a_q.rows, cols: shape_b_q.cols};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= st_idle;
            shape_a_q <= '0;
            shape_b_q <= '0;
            busy      <= 1'b0;
            is_valid  <= 1'b1;
        end else begin
            case (state)
                st_idle: begin
                    if (en) begin
                        shape_a_q <= shape_a;
                        shape_b_q <= shape_b;
                        busy      <= 1'b1;
                        state     <= st_check;
                    end
                end
                st_check: begin
                    if (dims_ok) begin
                        state <= st_compute;
                    end else begin
                        busy     <= 1'b0;
                        is_valid <= 1'b0;
                        state    <= st_error;
                    end
                end
                st_compute: begin
                    // en is ignored until the job ends
                    if (done) begin
                        state <= st_output;
                    end
                end
                st_output: begin
                    busy  <= 1'b0;
                    state <= st_finished;
                end
                st_finished, st_error: begin
                    if (!en) begin
                        is_valid <= 1'b1;
                        state    <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

/* mat_mul_top.sv */
`timescale 1ns/1ps

module mat_mul_top #(
    parameter int DATA_WIDTH = 9
) (
    input  logic                                                clk,
    input  logic                                                reset_n,
    input  mat_mul_pkg::mat_shape_t                             shape_a,
    input  logic [mat_mul_pkg::GRID_SIZE-1:0][DATA_WIDTH-1:0]   data_a,
    input  mat_mul_pkg::mat_shape_t                             shape_b,
    input  logic [mat_mul_pkg::GRID_SIZE-1:0][DATA_WIDTH-1:0]   data_b,
    input  logic                                                en,
    output mat_mul_pkg::mat_shape_t                             shape_out,
    output logic [mat_mul_pkg::GRID_SIZE-1:0][DATA_WIDTH-1:0]   data_out,
    output logic                                                busy,
    output logic                                                is_valid
);

    logic                    load;
    logic                    start;
    logic                    done;
    logic                    out_load;
    logic                    clear;
    mat_mul_pkg::mat_shape_t out_shape;

    logic [mat_mul_pkg::GRID_SIZE-1:0][DATA_WIDTH-1:0] grid_a;
    logic [mat_mul_pkg::GRID_SIZE-1:0][DATA_WIDTH-1:0] grid_b;
    logic [mat_mul_pkg::GRID_SIZE-1:0][DATA_WIDTH-1:0] result_grid;

    // operand A into padded grid
    mat_pack #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_pack_a (
        .clk      (clk),
        .reset_n  (reset_n),
        .load     (load),
        .shape    (shape_a),
        .dense_in (data_a),
        .grid     (grid_a)
    );

    // operand B into padded grid
    mat_pack #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_pack_b (
        .clk      (clk),
        .reset_n  (reset_n),
        .load     (load),
        .shape    (shape_b),
        .dense_in (data_b),
        .grid     (grid_b)
    );

    mat_dot_engine #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_engine (
        .clk         (clk),
        .reset_n     (reset_n),
        .start       (start),
        .grid_a      (grid_a),
        .grid_b      (grid_b),
        .result_grid (result_grid),
        .done        (done)
    );

    mat_unpack #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_unpack (
        .clk         (clk),
        .reset_n     (reset_n),
        .out_load    (out_load),
        .clear       (clear),
        .out_shape   (out_shape),
        .result_grid (result_grid),
        .shape_out   (shape_out),
        .data_out    (data_out)
    );

    mat_mul_ctrl u_ctrl (
        .clk       (clk),
        .reset_n   (reset_n),
        .en        (en),
        .shape_a   (shape_a),
        .shape_b   (shape_b),
        .done      (done),
        .load      (load),
        .start     (start),
        .out_load  (out_load),
        .clear     (clear),
        .out_shape (out_shape),
        .busy      (busy),
        .is_valid  (is_valid)
    );

endmodule

/* mat_mul_tb.sv */
`timescale 1ns/1ps

module mat_mul_tb;

    localparam int DW          = 9;
    localparam int CLK_PERIOD  = 4;
    localparam int SEED        = 12601;
    // busy falls at E28 together with the new data_out
    localparam int JOB_LATENCY = 28;
    localparam int JOB_LIMIT   = 40;
    // twelve job slots of JOB_LIMIT cycles, ten times over
    localparam int JOB_SLOTS   = 12;
    localparam int WATCHDOG_NS = 10 * JOB_SLOTS * JOB_LIMIT * CLK_PERIOD;

    typedef logic [mat_mul_pkg::GRID_SIZE-1:0][DW-1:0] grid_t;

    logic                    clk;
    logic                    reset_n;
    logic                    en;
    mat_mul_pkg::mat_shape_t shape_a;
    grid_t                   data_a;
    mat_mul_pkg::mat_shape_t shape_b;
    grid_t                   data_b;
    mat_mul_pkg::mat_shape_t shape_out;
    grid_t                   data_out;
    logic                    busy;
    logic                    is_valid;

    mat_mul_top #(
        .DATA_WIDTH (DW)
    ) u_mat_mul_top (
        .clk       (clk),
        .reset_n   (reset_n),
        .shape_a   (shape_a),
        .data_a    (data_a),
        .shape_b   (shape_b),
        .data_b    (data_b),
        .en        (en),
        .shape_out (shape_out),
        .data_out  (data_out),
        .busy      (busy),
        .is_valid  (is_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        stop_on_failure();
    end

    task automatic stop_on_failure();
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_data(input string name, input grid_t expected, input grid_t actual);
        if (actual !== expected) begin
            $display("** Error %s: data_out expected %h, actual %h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_shape(input string name, input mat_mul_pkg::mat_shape_t expected,
                               input mat_mul_pkg::mat_shape_t actual);
        if (actual !== expected) begin
            $display("** Error %s: shape_out expected %0dx%0d, actual %0dx%0d", name,
                     expected.rows, expected.cols, actual.rows, actual.cols);
            stop_on_failure();
        end
    endtask

    task automatic check_bit(input string name, input string what, input logic expected,
                             input logic actual);
        if (actual !== expected) begin
            $display("** Error %s: %s expected %b, actual %b", name, what, expected, actual);
            stop_on_failure();
        end
    endtask

    function automatic mat_mul_pkg::mat_shape_t shape_of(input int rows, input int cols);
        return '{rows: mat_mul_pkg::dim_t'(rows), cols: mat_mul_pkg::dim_t'(cols)};
    endfunction

    function automatic grid_t random_grid();
        grid_t g;
        for (int k = 0; k < mat_mul_pkg::GRID_SIZE; k++) begin
            g[k] = DW'($urandom);
        end
        return g;
    endfunction

    function automatic grid_t identity_grid();
        grid_t g;
        g = '0;
        for (int r = 0; r < mat_mul_pkg::MAX_DIM; r++) begin
            g[r * mat_mul_pkg::MAX_DIM + r] = DW'(1);
        end
        return g;
    endfunction

    // reference: pack to 5x5, multiply modulo 2**DW, unpack in dense order
    function automatic grid_t model_product(input mat_mul_pkg::mat_shape_t sa, input grid_t da,
                                            input mat_mul_pkg::mat_shape_t sb, input grid_t db);
        int    a [mat_mul_pkg::MAX_DIM][mat_mul_pkg::MAX_DIM];
        int    b [mat_mul_pkg::MAX_DIM][mat_mul_pkg::MAX_DIM];
        int    p [mat_mul_pkg::MAX_DIM][mat_mul_pkg::MAX_DIM];
        grid_t res;
        for (int r = 0; r < mat_mul_pkg::MAX_DIM; r++) begin
            for (int c = 0; c < mat_mul_pkg::MAX_DIM; c++) begin
                a[r][c] = 0;
                b[r][c] = 0;
                if (r < int'(sa.rows) && c < int'(sa.cols)) begin
                    a[r][c] = int'(da[r * int'(sa.cols) + c]);
                end
                if (r < int'(sb.rows) && c < int'(sb.cols)) begin
                    b[r][c] = int'(db[r * int'(sb.cols) + c]);
                end
            end
        end
        for (int i = 0; i < mat_mul_pkg::MAX_DIM; i++) begin
            for (int j = 0; j < mat_mul_pkg::MAX_DIM; j++) begin
                p[i][j] = 0;
                for (int k = 0; k < mat_mul_pkg::MAX_DIM; k++) begin
                    p[i][j] = (p[i][j] + a[i][k] * b[k][j]) % (1 << DW);
                end
            end
        end
        res = '0;
        for (int i = 0; i < int'(sa.rows); i++) begin
            for (int j = 0; j < int'(sb.cols); j++) begin
                res[i * int'(sb.cols) + j] = DW'(p[i][j]);
            end
        end
        return res;
    endfunction

    // starts and ends on a falling edge, en left high
    task automatic run_job(input string name, input mat_mul_pkg::mat_shape_t sa, input grid_t da,
                           input mat_mul_pkg::mat_shape_t sb, input grid_t db,
                           input grid_t expected);
        int   edges;
        logic busy_seen;
        shape_a   = sa;
        data_a    = da;
        shape_b   = sb;
        data_b    = db;
        en        = 1'b1;
        edges     = 0;
        busy_seen = 1'b1;
        while (busy_seen && edges < JOB_LIMIT) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            busy_seen = busy;
            if (busy) begin
                check_data(name, '0, data_out);
            end
        end
        if (edges != JOB_LATENCY) begin
            $display("** Error %s: busy fall edge expected %0d, actual %0d", name,
                     JOB_LATENCY, edges);
            stop_on_failure();
        end
        check_data(name, expected, data_out);
        check_shape(name, shape_of(int'(sa.rows), int'(sb.cols)), shape_out);
        check_bit(name, "is_valid", 1'b1, is_valid);
        // result holds while en stays high
        @(posedge clk);
        @(negedge clk);
        check_data(name, expected, data_out);
        check_bit(name, "busy", 1'b0, busy);
    endtask

    task automatic end_job(input string name);
        en = 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_data(name, '0, data_out);
        check_shape(name, '0, shape_out);
        check_bit(name, "is_valid", 1'b1, is_valid);
        check_bit(name, "busy", 1'b0, busy);
    endtask

    task automatic run_bad_job(input string name, input mat_mul_pkg::mat_shape_t sa,
                               input mat_mul_pkg::mat_shape_t sb);
        shape_a = sa;
        data_a  = random_grid();
        shape_b = sb;
        data_b  = random_grid();
        en      = 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_bit(name, "busy at E1", 1'b1, busy);
        @(posedge clk);
        @(negedge clk);
        check_bit(name, "busy at E2", 1'b0, busy);
        check_bit(name, "is_valid at E2", 1'b0, is_valid);
        @(posedge clk);
        @(negedge clk);
        check_bit(name, "is_valid", 1'b0, is_valid);
        check_data(name, '0, data_out);
        check_shape(name, '0, shape_out);
        end_job(name);
    endtask

    task automatic test_reset();
        check_bit("reset", "busy", 1'b0, busy);
        check_bit("reset", "is_valid", 1'b1, is_valid);
        check_data("reset", '0, data_out);
        check_shape("reset", '0, shape_out);
    endtask

    task automatic test_full_size();
        grid_t a;
        grid_t b;
        b = random_grid();
        run_job("identity", shape_of(5, 5), identity_grid(), shape_of(5, 5), b, b);
        end_job("identity");
        a = random_grid();
        b = random_grid();
        run_job("full_random", shape_of(5, 5), a, shape_of(5, 5), b,
                model_product(shape_of(5, 5), a, shape_of(5, 5), b));
        end_job("full_random");
    endtask

    task automatic test_non_square();
        grid_t a;
        grid_t b;
        // slots past the operand size carry junk that must be ignored
        a = random_grid();
        b = random_grid();
        run_job("2x3_3x4", shape_of(2, 3), a, shape_of(3, 4), b,
                model_product(shape_of(2, 3), a, shape_of(3, 4), b));
        end_job("2x3_3x4");
        a = random_grid();
        b = random_grid();
        run_job("1x5_5x1", shape_of(1, 5), a, shape_of(5, 1), b,
                model_product(shape_of(1, 5), a, shape_of(5, 1), b));
        end_job("1x5_5x1");
    endtask

    task automatic test_mismatch();
        run_bad_job("inner_3x2_3x3", shape_of(3, 2), shape_of(3, 3));
        run_bad_job("zero_dim", shape_of(0, 3), shape_of(3, 2));
        run_bad_job("dim_above_5", shape_of(2, 6), shape_of(6, 2));
    endtask

    task automatic test_clear_restart();
        grid_t a;
        grid_t b;
        a = random_grid();
        b = random_grid();
        run_job("first_job", shape_of(4, 3), a, shape_of(3, 5), b,
                model_product(shape_of(4, 3), a, shape_of(3, 5), b));
        end_job("first_job");
        a = random_grid();
        b = random_grid();
        run_job("second_job", shape_of(3, 4), a, shape_of(4, 2), b,
                model_product(shape_of(3, 4), a, shape_of(4, 2), b));
        end_job("second_job");
    endtask

    initial begin
        int unsigned seed_draw;
        seed_draw = $urandom(SEED);
        reset_n   = 1'b0;
        en        = 1'b0;
        shape_a   = '0;
        data_a    = '0;
        shape_b   = '0;
        data_b    = '0;
        repeat (4) @(negedge clk);
        reset_n = 1'b1;
        test_reset();
        test_full_size();
        test_non_square();
        test_mismatch();
        test_clear_restart();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* all.f */
mat_mul_pkg.sv
mat_pack.sv
mat_dot_engine.sv
mat_unpack.sv
mat_mul_ctrl.sv
mat_mul_top.sv
mat_mul_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -f all.f --top-module mat_mul_tb -o mat_mul_tb_sim
	./obj_dir/mat_mul_tb_sim

clean:
	rm -rf obj_dir
